//--- verilog/core_settings.svh
// *********************************************************************
// rv32i core widths and opcodes
// *********************************************************************
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

`define CORE_XLEN       32
`define CORE_NUM_REGS   32
`define CORE_REG_AW     5
`define CORE_RESET_PC   32'h8000_0000

// major opcodes, inst[6:0]
`define CORE_OPC_OP      7'b0110011
`define CORE_OPC_OP_IMM  7'b0010011
`define CORE_OPC_LUI     7'b0110111
`define CORE_OPC_AUIPC   7'b0010111
`define CORE_OPC_JAL     7'b1101111
`define CORE_OPC_JALR    7'b1100111
`define CORE_OPC_BRANCH  7'b1100011

`endif

//--- verilog/core_pkg.sv
// *********************************************************************
// rv32i core shared types
// *********************************************************************
`default_nettype none
`include "core_settings.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]   word_t;
    typedef logic [`CORE_REG_AW-1:0] reg_addr_t;

    // instruction format, picked from the opcode
    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_S,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_N     // no operands, retires as a no-op
    } inst_type_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

endpackage

`default_nettype wire

//--- verilog/alu.sv
// *********************************************************************
// integer alu
// *********************************************************************
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  wire core_pkg::word_t   a,
    input  wire core_pkg::word_t   b,
    input  wire core_pkg::alu_op_t op,
    output core_pkg::word_t        result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];  // rv32 shifts use 5 bits

    always_comb begin
        unique case (op)
            core_pkg::ALU_ADD:  result = a + b;
            core_pkg::ALU_SUB:  result = a - b;
            core_pkg::ALU_SLL:  result = a << shamt;
            core_pkg::ALU_SLT:  result = core_pkg::word_t'($signed(a) < $signed(b));
            core_pkg::ALU_SLTU: result = core_pkg::word_t'(a < b);
            core_pkg::ALU_XOR:  result = a ^ b;
            core_pkg::ALU_SRL:  result = a >> shamt;
            core_pkg::ALU_SRA:  result = $unsigned($signed(a) >>> shamt);  // keeps the sign bit
            core_pkg::ALU_OR:   result = a | b;
            core_pkg::ALU_AND:  result = a & b;
            default:            result = a + b;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/fetch_unit.sv
// *********************************************************************
// instruction fetch and pc register
// *********************************************************************
`timescale 1ns/100ps
`default_nettype none
`include "core_settings.svh"

module fetch_unit (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  inst_valid,
    input  wire                  retire_valid,
    input  wire core_pkg::word_t retire_next_pc,
    output logic                 inst_req,
    output core_pkg::word_t      pc,
    output logic                 dec_start
);

    typedef enum logic {
        IDLE,
        WAIT
    } state_t;

    state_t state;
    logic   boot;   // high until the first request goes out

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            boot     <= 1'b1;
            inst_req <= 1'b0;
        end else begin
            boot     <= 1'b0;
            inst_req <= boot || retire_valid;  // re-arm the cycle after retire
            unique case (state)
                IDLE:    if (inst_req) state <= WAIT;
                WAIT:    if (inst_valid) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // pc holds from request until the instruction retires
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CORE_RESET_PC;
        end else if (retire_valid) begin
            pc <= retire_next_pc;  // sequential or jump target, resolved in execute
        end
    end

    assign dec_start = inst_valid && (state == WAIT);

    // one instruction in flight, responses outside the wait window are stray
    a_valid_only_in_wait: assert property (
        @(posedge clk) disable iff (reset) inst_valid |-> state == WAIT
    ) else $error("inst_valid arrived while fetch was not waiting");

endmodule

`default_nettype wire

//--- verilog/decode_unit.sv
// *********************************************************************
// instruction decode stage
// *********************************************************************
`timescale 1ns/100ps
`default_nettype none
`include "core_settings.svh"

module decode_unit (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   dec_start,
    input  wire core_pkg::word_t  inst,
    input  wire core_pkg::word_t  pc,
    output core_pkg::reg_addr_t   rs1_addr,
    output core_pkg::reg_addr_t   rs2_addr,
    input  wire core_pkg::word_t  rs1_data,
    input  wire core_pkg::word_t  rs2_data,
    output logic                  dec_valid,
    output core_pkg::word_t       dec_pc,
    output logic [2:0]            dec_funct3,
    output logic [6:0]            dec_opcode,
    output core_pkg::inst_type_t  dec_type,
    output core_pkg::alu_op_t     dec_alu_op,
    output core_pkg::word_t       dec_imm,
    output core_pkg::reg_addr_t   dec_rd,
    output core_pkg::word_t       dec_src1,
    output core_pkg::word_t       dec_src2
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    core_pkg::inst_type_t inst_type;
    core_pkg::alu_op_t    alu_op;
    core_pkg::word_t      imm;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7   = inst[31:25];
    assign rs1_addr = inst[19:15];  // straight to the register file read ports
    assign rs2_addr = inst[24:20];

    always_comb begin
        unique case (opcode)
            `CORE_OPC_OP:                      inst_type = core_pkg::TYPE_R;
            `CORE_OPC_OP_IMM, `CORE_OPC_JALR:  inst_type = core_pkg::TYPE_I;
            `CORE_OPC_BRANCH:                  inst_type = core_pkg::TYPE_B;
            `CORE_OPC_LUI, `CORE_OPC_AUIPC:    inst_type = core_pkg::TYPE_U;
            `CORE_OPC_JAL:                     inst_type = core_pkg::TYPE_J;
            default:                           inst_type = core_pkg::TYPE_N;
        endcase
    end

    // sign-extended immediates per format
    always_comb begin
        unique case (inst_type)
            core_pkg::TYPE_I: imm = {{20{inst[31]}}, inst[31:20]};
            core_pkg::TYPE_S: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            core_pkg::TYPE_B: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            core_pkg::TYPE_U: imm = {inst[31:12], 12'b0};
            core_pkg::TYPE_J: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:          imm = '0;
        endcase
    end

    // everything outside OP / OP-IMM uses the adder
    always_comb begin
        alu_op = core_pkg::ALU_ADD;
        if (opcode == `CORE_OPC_OP || opcode == `CORE_OPC_OP_IMM) begin
            unique case (funct3)
                3'b000: if (inst_type == core_pkg::TYPE_R && funct7[5]) alu_op = core_pkg::ALU_SUB;
                3'b001: alu_op = core_pkg::ALU_SLL;
                3'b010: alu_op = core_pkg::ALU_SLT;
                3'b011: alu_op = core_pkg::ALU_SLTU;
                3'b100: alu_op = core_pkg::ALU_XOR;
                3'b101: alu_op = funct7[5] ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
                3'b110: alu_op = core_pkg::ALU_OR;
                3'b111: alu_op = core_pkg::ALU_AND;
                default: alu_op = core_pkg::ALU_ADD;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) dec_valid <= 1'b0;
        else dec_valid <= dec_start;
    end

    // decode stage register, loaded once per accepted instruction
    always_ff @(posedge clk) begin
        if (dec_start) begin
            dec_pc     <= pc;
            dec_funct3 <= funct3;
            dec_opcode <= opcode;
            dec_type   <= inst_type;
            dec_alu_op <= alu_op;
            dec_imm    <= imm;
            dec_rd     <= inst[11:7];
            dec_src1   <= rs1_data;
            dec_src2   <= rs2_data;
        end
    end

endmodule

`default_nettype wire

//--- verilog/reg_file.sv
// *********************************************************************
// general purpose register file
// *********************************************************************
`timescale 1ns/100ps
`default_nettype none
`include "core_settings.svh"

module reg_file (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      wen,
    input  wire core_pkg::reg_addr_t waddr,
    input  wire core_pkg::word_t     wdata,
    input  wire core_pkg::reg_addr_t raddr1,
    input  wire core_pkg::reg_addr_t raddr2,
    output core_pkg::word_t          rdata1,
    output core_pkg::word_t          rdata2
);

    core_pkg::word_t regs [`CORE_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 reads as zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // execute filters rd == 0 out of the retire write enable
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (reset) wen |-> waddr != '0
    ) else $error("write to x0 reached the register file");

endmodule

`default_nettype wire

//--- verilog/execute_unit.sv
// *********************************************************************
// execute and writeback stage
// *********************************************************************
`timescale 1ns/100ps
`default_nettype none
`include "core_settings.svh"

module execute_unit (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       dec_valid,
    input  wire core_pkg::word_t      dec_pc,
    input  wire [2:0]                 dec_funct3,
    input  wire [6:0]                 dec_opcode,
    input  wire core_pkg::inst_type_t dec_type,
    input  wire core_pkg::alu_op_t    dec_alu_op,
    input  wire core_pkg::word_t      dec_imm,
    input  wire core_pkg::reg_addr_t  dec_rd,
    input  wire core_pkg::word_t      dec_src1,
    input  wire core_pkg::word_t      dec_src2,
    output logic                      retire_valid,
    output core_pkg::word_t           retire_pc,
    output logic                      retire_we,
    output core_pkg::reg_addr_t       retire_rd,
    output core_pkg::word_t           retire_wdata,
    output core_pkg::word_t           retire_next_pc
);

    core_pkg::word_t alu_a;
    core_pkg::word_t alu_b;
    core_pkg::word_t alu_result;
    core_pkg::word_t link;
    core_pkg::word_t next_pc;
    core_pkg::word_t wdata;
    logic            taken;
    logic            writes;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (dec_alu_op),
        .result (alu_result)
    );

    // operand select, R type and no-ops keep rs1/rs2
    always_comb begin
        alu_a = dec_src1;
        alu_b = dec_src2;
        unique case (dec_type)
            core_pkg::TYPE_I: alu_b = dec_imm;
            core_pkg::TYPE_U: begin
                alu_a = (dec_opcode == `CORE_OPC_LUI) ? '0 : dec_pc;
                alu_b = dec_imm;
            end
            core_pkg::TYPE_B, core_pkg::TYPE_J: begin
                alu_a = dec_pc;   // adder forms the pc-relative target
                alu_b = dec_imm;
            end
            default: ;
        endcase
    end

    always_comb begin
        unique case (dec_funct3)
            3'b000:  taken = (dec_src1 == dec_src2);                   // beq
            3'b001:  taken = (dec_src1 != dec_src2);                   // bne
            3'b100:  taken = ($signed(dec_src1) < $signed(dec_src2));  // blt
            3'b101:  taken = ($signed(dec_src1) >= $signed(dec_src2)); // bge
            3'b110:  taken = (dec_src1 < dec_src2);                    // bltu
            3'b111:  taken = (dec_src1 >= dec_src2);                   // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign link = dec_pc + 32'd4;

    // next pc and writeback choice
    always_comb begin
        next_pc = link;
        wdata   = alu_result;
        writes  = 1'b0;
        unique case (dec_type)
            core_pkg::TYPE_R, core_pkg::TYPE_U: writes = 1'b1;
            core_pkg::TYPE_I: begin
                writes = 1'b1;
                if (dec_opcode == `CORE_OPC_JALR) begin
                    next_pc = {alu_result[`CORE_XLEN-1:1], 1'b0};
                    wdata   = link;
                end
            end
            core_pkg::TYPE_J: begin
                writes  = 1'b1;
                next_pc = alu_result;
                wdata   = link;
            end
            core_pkg::TYPE_B: if (taken) next_pc = alu_result;
            default: ;  // unknown opcodes fall through as no-ops
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
        end else begin
            retire_valid <= dec_valid;
            retire_we    <= dec_valid && writes && (dec_rd != '0);  // pulses with retire_valid
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            retire_pc      <= dec_pc;
            retire_rd      <= dec_rd;
            retire_wdata   <= wdata;
            retire_next_pc <= next_pc;
        end
    end

    // single issue, fetch cannot refill decode fast enough for back-to-back retires
    a_retire_single: assert property (
        @(posedge clk) disable iff (reset) retire_valid |=> !retire_valid
    ) else $error("retire_valid held for two cycles");

endmodule

`default_nettype wire

//--- verilog/core_top.sv
// *********************************************************************
// rv32i core top
// *********************************************************************
`timescale 1ns/100ps
`default_nettype none

module core_top (
    input  wire                  clk,
    input  wire                  reset,
    output logic                 inst_req,
    output core_pkg::word_t      pc,
    input  wire                  inst_valid,
    input  wire core_pkg::word_t inst,
    output logic                 retire_valid,
    output core_pkg::word_t      retire_pc,
    output logic                 retire_we,
    output core_pkg::reg_addr_t  retire_rd,
    output core_pkg::word_t      retire_wdata,
    output core_pkg::word_t      retire_next_pc
);

    logic                 dec_start;
    core_pkg::reg_addr_t  rs1_addr;
    core_pkg::reg_addr_t  rs2_addr;
    core_pkg::word_t      rs1_data;
    core_pkg::word_t      rs2_data;
    logic                 dec_valid;
    core_pkg::word_t      dec_pc;
    logic [2:0]           dec_funct3;
    logic [6:0]           dec_opcode;
    core_pkg::inst_type_t dec_type;
    core_pkg::alu_op_t    dec_alu_op;
    core_pkg::word_t      dec_imm;
    core_pkg::reg_addr_t  dec_rd;
    core_pkg::word_t      dec_src1;
    core_pkg::word_t      dec_src2;

    fetch_unit u_fetch_unit (
        .clk            (clk),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .retire_valid   (retire_valid),
        .retire_next_pc (retire_next_pc),
        .inst_req       (inst_req),
        .pc             (pc),
        .dec_start      (dec_start)
    );

    decode_unit u_decode_unit (
        .clk        (clk),
        .reset      (reset),
        .dec_start  (dec_start),
        .inst       (inst),
        .pc         (pc),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .dec_valid  (dec_valid),
        .dec_pc     (dec_pc),
        .dec_funct3 (dec_funct3),
        .dec_opcode (dec_opcode),
        .dec_type   (dec_type),
        .dec_alu_op (dec_alu_op),
        .dec_imm    (dec_imm),
        .dec_rd     (dec_rd),
        .dec_src1   (dec_src1),
        .dec_src2   (dec_src2)
    );

    // retire_we only pulses alongside retire_valid
    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .wen    (retire_we),
        .waddr  (retire_rd),
        .wdata  (retire_wdata),
        .raddr1 (rs1_addr),
        .raddr2 (rs2_addr),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    execute_unit u_execute_unit (
        .clk            (clk),
        .reset          (reset),
        .dec_valid      (dec_valid),
        .dec_pc         (dec_pc),
        .dec_funct3     (dec_funct3),
        .dec_opcode     (dec_opcode),
        .dec_type       (dec_type),
        .dec_alu_op     (dec_alu_op),
        .dec_imm        (dec_imm),
        .dec_rd         (dec_rd),
        .dec_src1       (dec_src1),
        .dec_src2       (dec_src2),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_we      (retire_we),
        .retire_rd      (retire_rd),
        .retire_wdata   (retire_wdata),
        .retire_next_pc (retire_next_pc)
    );

endmodule

`default_nettype wire

//--- sim/core_model.svh
// *********************************************************************
// rv32i architectural reference model
// *********************************************************************
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

core_pkg::word_t model_pc;
core_pkg::word_t model_regs [`CORE_NUM_REGS];

function automatic void model_reset();
    model_pc = `CORE_RESET_PC;
    foreach (model_regs[i]) begin
        model_regs[i] = '0;
    end
endfunction

// funct3 selects the operation, alt is inst[30] where it matters
function automatic core_pkg::word_t alu_ref(input logic [2:0] funct3, input logic alt,
                                            input core_pkg::word_t a, input core_pkg::word_t b);
    core_pkg::word_t r;
    case (funct3)
        3'b000: r = alt ? a - b : a + b;
        3'b001: r = a << b[4:0];
        3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: r = (a < b) ? 32'd1 : 32'd0;
        3'b100: r = a ^ b;
        3'b101: begin
            if (alt)
                r = $signed(a) >>> b[4:0];  // sign fills from the left
            else
                r = a >> b[4:0];
        end
        3'b110: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

function automatic logic branch_ref(input logic [2:0] funct3,
                                    input core_pkg::word_t a, input core_pkg::word_t b);
    case (funct3)
        3'b000: return a == b;
        3'b001: return a != b;
        3'b100: return $signed(a) < $signed(b);
        3'b101: return $signed(a) >= $signed(b);
        3'b110: return a < b;
        3'b111: return a >= b;
        default: return 1'b0;
    endcase
endfunction

// applies one instruction to the model state and returns the expected retire
function automatic void model_execute(input core_pkg::word_t insn, output logic we,
                                      output core_pkg::reg_addr_t rd,
                                      output core_pkg::word_t wdata,
                                      output core_pkg::word_t next_pc);
    core_pkg::word_t a;
    core_pkg::word_t b;
    core_pkg::word_t imm_i;
    core_pkg::word_t imm_b;
    core_pkg::word_t imm_u;
    core_pkg::word_t imm_j;
    logic [2:0]      f3;
    a       = model_regs[insn[19:15]];
    b       = model_regs[insn[24:20]];
    f3      = insn[14:12];
    rd      = insn[11:7];
    imm_i   = $signed(insn) >>> 20;
    imm_b   = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_u   = {insn[31:12], 12'h000};
    imm_j   = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    we      = 1'b0;
    wdata   = '0;
    next_pc = model_pc + 32'd4;
    case (insn[6:0])
        `CORE_OPC_OP: begin
            we    = 1'b1;
            wdata = alu_ref(f3, insn[30], a, b);
        end
        `CORE_OPC_OP_IMM: begin
            we    = 1'b1;
            wdata = alu_ref(f3, (f3 == 3'b101) && insn[30], a, imm_i);  // no subi
        end
        `CORE_OPC_LUI: begin
            we    = 1'b1;
            wdata = imm_u;
        end
        `CORE_OPC_AUIPC: begin
            we    = 1'b1;
            wdata = model_pc + imm_u;
        end
        `CORE_OPC_JAL: begin
            we      = 1'b1;
            wdata   = model_pc + 32'd4;
            next_pc = model_pc + imm_j;
        end
        `CORE_OPC_JALR: begin
            we      = 1'b1;
            wdata   = model_pc + 32'd4;
            next_pc = (a + imm_i) & ~32'd1;
        end
        `CORE_OPC_BRANCH: begin
            if (branch_ref(f3, a, b)) next_pc = model_pc + imm_b;
        end
        default: ;  // anything else is a no-op
    endcase
    if (rd == '0) we = 1'b0;
    if (we) model_regs[rd] = wdata;
    model_pc = next_pc;
endfunction

`endif

//--- sim/core_tb.sv
// *********************************************************************
// rv32i core testbench
// *********************************************************************
`timescale 1ns/100ps
`default_nettype none
`include "core_settings.svh"

module core_tb;

    localparam int NUM_INSTS = 400;
    localparam int TIMEOUT   = 50;  // cycles per wait

    logic                clk = 1'b0;
    logic                reset;
    logic                inst_req;
    core_pkg::word_t     pc;
    logic                inst_valid;
    core_pkg::word_t     inst;
    logic                retire_valid;
    core_pkg::word_t     retire_pc;
    logic                retire_we;
    core_pkg::reg_addr_t retire_rd;
    core_pkg::word_t     retire_wdata;
    core_pkg::word_t     retire_next_pc;

    integer seed = 30308;

    `include "core_model.svh"

    core_top u_core_top (
        .clk            (clk),
        .reset          (reset),
        .inst_req       (inst_req),
        .pc             (pc),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_we      (retire_we),
        .retire_rd      (retire_rd),
        .retire_wdata   (retire_wdata),
        .retire_next_pc (retire_next_pc)
    );

    always #2 clk = ~clk;  // 4 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input core_pkg::word_t expected,
                              input core_pkg::word_t actual);
        if (actual !== expected)
            abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_reg(input string name, input core_pkg::reg_addr_t expected,
                             input core_pkg::reg_addr_t actual);
        if (actual !== expected)
            abort_run($sformatf("[FAIL] %s expected %0d actual %0d", name, expected, actual));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            abort_run($sformatf("[FAIL] %s expected %b actual %b", name, expected, actual));
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected)
            abort_run($sformatf("[FAIL] %s expected %0d actual %0d", name, expected, actual));
    endtask

    function automatic string kind_name(input int kind);
        case (kind)
            0: return "op";
            1: return "op_imm";
            2: return "lui";
            3: return "auipc";
            4: return "jal";
            5: return "jalr";
            6: return "branch";
            default: return "unsupported";
        endcase
    endfunction

    // random encoding of the given kind, fields drawn from one random word
    function automatic core_pkg::word_t make_inst(input int kind);
        logic [31:0]         r;
        logic [6:0]          funct7;
        logic [6:0]          opc;
        logic [2:0]          funct3;
        logic [11:0]         imm12;
        core_pkg::reg_addr_t rd;
        core_pkg::reg_addr_t rs1;
        core_pkg::reg_addr_t rs2;
        core_pkg::word_t     word;
        r      = $random(seed);
        rd     = r[11:7];
        funct3 = r[14:12];
        rs1    = r[19:15];
        rs2    = r[24:20];
        imm12  = r[31:20];
        funct7 = r[30] ? 7'h20 : 7'h00;
        case (kind)
            0: begin
                if (funct3 != 3'b000 && funct3 != 3'b101) funct7 = 7'h00;
                word = {funct7, rs2, rs1, funct3, rd, `CORE_OPC_OP};
            end
            1: begin
                if (funct3 == 3'b001) imm12[11:5] = 7'h00;  // slli
                if (funct3 == 3'b101) imm12[11:5] = funct7;  // srli or srai
                word = {imm12, rs1, funct3, rd, `CORE_OPC_OP_IMM};
            end
            2: word = {r[31:12], rd, `CORE_OPC_LUI};
            3: word = {r[31:12], rd, `CORE_OPC_AUIPC};
            4: word = {r[31:12], rd, `CORE_OPC_JAL};
            5: word = {imm12, rs1, 3'b000, rd, `CORE_OPC_JALR};
            6: begin
                if (funct3[2:1] == 2'b01) funct3[1] = 1'b0;  // fold 010/011 onto beq/bne
                if (r[6:5] == 2'b00) rs2 = rs1;  // equal operands now and then
                word = {r[31:25], rs2, rs1, funct3, r[11:7], `CORE_OPC_BRANCH};
            end
            default: begin
                case (r[1:0])
                    2'b00: opc = 7'b0000011;  // load
                    2'b01: opc = 7'b0100011;  // store
                    2'b10: opc = 7'b1110011;  // system
                    default: opc = 7'b0001111;  // fence
                endcase
                word = {r[31:7], opc};
            end
        endcase
        return word;
    endfunction

    task automatic wait_for_request(input string name);
        int cycles;
        cycles = 0;
        while (inst_req !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT)
                abort_run($sformatf("%s: inst_req never came", name));
        end
    endtask

    // drops inst_valid after one cycle and counts cycles up to retire
    task automatic wait_for_retire(input string name, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            inst_valid = 1'b0;
            cycles++;
            if (inst_req)
                abort_run($sformatf("%s: inst_req rose before the retire", name));
            if (cycles > TIMEOUT)
                abort_run($sformatf("%s: retire_valid never came", name));
        end while (retire_valid !== 1'b1);
    endtask

    initial begin
        core_pkg::word_t     req_pc;
        core_pkg::word_t     exp_wdata;
        core_pkg::word_t     exp_next_pc;
        core_pkg::reg_addr_t exp_rd;
        logic                exp_we;
        int                  kind;
        int                  delay;
        int                  latency;
        string               name;

        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        model_reset();
        repeat (4) begin
            @(negedge clk);
            check_bit("reset retire_valid", 1'b0, retire_valid);
            check_bit("reset inst_req", 1'b0, inst_req);
            check_word("reset pc", `CORE_RESET_PC, pc);
        end
        reset = 1'b0;

        for (int n = 0; n < NUM_INSTS; n++) begin
            kind = $unsigned($random(seed)) % 8;
            name = $sformatf("inst %0d %s", n, kind_name(kind));
            wait_for_request(name);
            check_word({name, " request pc"}, model_pc, pc);
            req_pc = model_pc;

            delay = 1 + $unsigned($random(seed)) % 4;  // memory latency
            repeat (delay) @(negedge clk);
            inst       = make_inst(kind);
            inst_valid = 1'b1;
            model_execute(inst, exp_we, exp_rd, exp_wdata, exp_next_pc);

            wait_for_retire(name, latency);
            check_count({name, " retire latency"}, 2, latency);
            check_word({name, " retire_pc"}, req_pc, retire_pc);
            check_bit({name, " retire_we"}, exp_we, retire_we);
            if (exp_we) begin
                check_reg({name, " retire_rd"}, exp_rd, retire_rd);
                check_word({name, " retire_wdata"}, exp_wdata, retire_wdata);
            end
            check_word({name, " retire_next_pc"}, exp_next_pc, retire_next_pc);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+verilog
+incdir+sim
verilog/core_pkg.sv
verilog/alu.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/reg_file.sv
verilog/execute_unit.sv
verilog/core_top.sv
sim/core_tb.sv
